// File: bridge_pkg.sv
`default_nettype none

package bridge_pkg;

    localparam int addr_width = 40;
    localparam int data_width = 64;        // axi and noc side alike
    localparam int strb_width = data_width / 8;
    localparam int fifo_depth = 16;
    localparam int fifo_ptr_width = $clog2(fifo_depth);

    // node identifiers
    localparam int chipid_width = 14;
    localparam int xy_width = 8;
    localparam int fbits_width = 4;

    localparam int msg_addr_width = 48;    // address field of header flit 1
    localparam int length_width = 8;
    localparam int type_width = 8;
    localparam int mshrid_width = 8;
    localparam int size_width = 3;

    // header flit 0, destination and message info
    localparam int hdr0_dst_chipid_lsb = 50;
    localparam int hdr0_dst_x_lsb = 42;
    localparam int hdr0_dst_y_lsb = 34;
    localparam int hdr0_dst_fbits_lsb = 30;
    localparam int hdr0_length_lsb = 22;
    localparam int hdr0_type_lsb = 14;
    localparam int hdr0_mshrid_lsb = 6;

    // header flit 1
    localparam int hdr1_addr_lsb = 16;
    localparam int hdr1_size_lsb = 0;

    // header flit 2, source node
    localparam int hdr2_src_chipid_lsb = 50;
    localparam int hdr2_src_x_lsb = 42;
    localparam int hdr2_src_y_lsb = 34;
    localparam int hdr2_src_fbits_lsb = 30;

    // flits following the first one
    localparam logic [length_width-1:0] store_length = 8'd3;
    localparam logic [length_width-1:0] load_length = 8'd2;
    localparam logic [1:0] last_hdr_flit = 2'd2;  // three header flits

    typedef enum logic [type_width-1:0] {
        msg_nc_load_req  = 8'd14,
        msg_nc_store_req = 8'd15
    } msg_type_t;

    typedef enum logic {
        req_load  = 1'b0,
        req_store = 1'b1
    } req_kind_t;

    typedef enum logic [size_width-1:0] {
        size_1b = 3'd1,
        size_2b = 3'd2,
        size_4b = 3'd3,
        size_8b = 3'd4
    } size_code_t;

    typedef enum logic [1:0] {
        st_idle   = 2'd0,
        st_header = 2'd1,
        st_data   = 2'd2
    } flit_state_t;

endpackage

`default_nettype wire

// File: bridge_if.sv
`default_nettype none

// head of the request queue, decode to former
interface req_if;
    logic                                    req_valid;
    bridge_pkg::req_kind_t                   kind;
    logic [bridge_pkg::addr_width-1:0]       addr;
    logic [bridge_pkg::data_width-1:0]       wdata;
    logic [bridge_pkg::strb_width-1:0]       wstrb;
    logic                                    req_take;   // pops the head

    modport source (output req_valid, kind, addr, wdata, wstrb, input req_take);
    modport sink (input req_valid, kind, addr, wdata, wstrb, output req_take);
endinterface

// formed message, former to serializer
interface msg_if;
    logic                                    msg_valid;
    bridge_pkg::req_kind_t                   kind;
    bridge_pkg::msg_type_t                   msg_type;
    logic [bridge_pkg::length_width-1:0]     length;
    logic [bridge_pkg::addr_width-1:0]       address;
    bridge_pkg::size_code_t                  data_size;
    logic [bridge_pkg::data_width-1:0]       wdata;
    logic                                    msg_done;   // last flit accepted

    modport source (output msg_valid, kind, msg_type, length, address, data_size, wdata,
                    input msg_done);
    modport sink (input msg_valid, kind, msg_type, length, address, data_size, wdata,
                  output msg_done);
endinterface

`default_nettype wire

// File: req_fifo.sv
`default_nettype none

module req_fifo #(
    parameter int width = 8
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             wr_en,
    input  logic             rd_en,
    input  logic [width-1:0] wr_data,
    output logic [width-1:0] rd_data,
    output logic             full,
    output logic             empty
);

    logic [width-1:0] mem [bridge_pkg::fifo_depth];
    logic [bridge_pkg::fifo_ptr_width-1:0] wr_ptr;
    logic [bridge_pkg::fifo_ptr_width-1:0] rd_ptr;
    logic [bridge_pkg::fifo_ptr_width:0] count;
    logic wr_fire;
    logic rd_fire;

    assign wr_fire = wr_en & ~full;
    assign rd_fire = rd_en & ~empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (wr_fire) wr_ptr <= wr_ptr + 1'b1;  // wraps, depth is a power of two
            if (rd_fire) rd_ptr <= rd_ptr + 1'b1;
            case ({wr_fire, rd_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) mem[wr_ptr] <= wr_data;
    end

    assign rd_data = mem[rd_ptr];  // head shown directly
    assign full = count[bridge_pkg::fifo_ptr_width];
    assign empty = (count == '0);

endmodule

`default_nettype wire

// File: axi_req_decode.sv
`default_nettype none

module axi_req_decode (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [bridge_pkg::addr_width-1:0] awaddr,
    input  logic                              awvalid,
    output logic                              awready,
    input  logic [bridge_pkg::data_width-1:0] wdata,
    input  logic [bridge_pkg::strb_width-1:0] wstrb,
    input  logic                              wvalid,
    output logic                              wready,
    input  logic [bridge_pkg::addr_width-1:0] araddr,
    input  logic                              arvalid,
    output logic                              arready,
    req_if.source                             req
);

    logic store_accept;
    logic load_accept;
    logic head_store;

    logic [0:0] kind_in;
    logic [0:0] kind_head;
    logic kind_full, kind_empty;
    logic waddr_full, waddr_empty;
    logic wdata_full, wdata_empty;
    logic raddr_full, raddr_empty;
    logic [bridge_pkg::addr_width-1:0] waddr_head;
    logic [bridge_pkg::addr_width-1:0] raddr_head;
    logic [bridge_pkg::strb_width+bridge_pkg::data_width-1:0] wdata_head;

    // write side needs address and data together
    assign awready = ~rst & ~kind_full & ~waddr_full & ~wdata_full;
    assign wready = awready;
    assign store_accept = awvalid & wvalid & awready;

    assign arready = ~rst & ~kind_full & ~raddr_full & ~store_accept;  // stores win
    assign load_accept = arvalid & arready;

    assign kind_in = store_accept ? bridge_pkg::req_store : bridge_pkg::req_load;

    req_fifo #(.width(1)) kind_fifo (
        .clk(clk), .rst(rst),
        .wr_en(store_accept | load_accept), .rd_en(req.req_take),
        .wr_data(kind_in), .rd_data(kind_head),
        .full(kind_full), .empty(kind_empty)
    );

    req_fifo #(.width(bridge_pkg::addr_width)) waddr_fifo (
        .clk(clk), .rst(rst),
        .wr_en(store_accept), .rd_en(req.req_take & head_store),
        .wr_data(awaddr), .rd_data(waddr_head),
        .full(waddr_full), .empty(waddr_empty)
    );

    // strobe travels with its data
    req_fifo #(.width(bridge_pkg::strb_width + bridge_pkg::data_width)) wdata_fifo (
        .clk(clk), .rst(rst),
        .wr_en(store_accept), .rd_en(req.req_take & head_store),
        .wr_data({wstrb, wdata}), .rd_data(wdata_head),
        .full(wdata_full), .empty(wdata_empty)
    );

    req_fifo #(.width(bridge_pkg::addr_width)) raddr_fifo (
        .clk(clk), .rst(rst),
        .wr_en(load_accept), .rd_en(req.req_take & ~head_store),
        .wr_data(araddr), .rd_data(raddr_head),
        .full(raddr_full), .empty(raddr_empty)
    );

    assign head_store = (kind_head == bridge_pkg::req_store);

    // kind fifo orders the two request streams
    assign req.req_valid = ~kind_empty &
                           (head_store ? (~waddr_empty & ~wdata_empty) : ~raddr_empty);
    assign req.kind = bridge_pkg::req_kind_t'(kind_head);
    assign req.addr = head_store ? waddr_head : raddr_head;
    assign req.wdata = wdata_head[bridge_pkg::data_width-1:0];
    assign req.wstrb = wdata_head[bridge_pkg::strb_width+bridge_pkg::data_width-1:
                                  bridge_pkg::data_width];

endmodule

`default_nettype wire

// File: msg_former.sv
`default_nettype none

module msg_former (
    input logic    clk,
    input logic    rst,
    req_if.sink    req,
    msg_if.source  msg
);

    logic take;
    logic is_store;
    logic [2:0] strb_offset;
    bridge_pkg::size_code_t strb_size;

    // next request goes in when the slot is empty or being freed
    assign take = req.req_valid & (~msg.msg_valid | msg.msg_done);
    assign req.req_take = take;
    assign is_store = (req.kind == bridge_pkg::req_store);

    // strobe to size and byte offset
    always_comb begin
        strb_size = bridge_pkg::size_8b;  // illegal patterns fall back here
        strb_offset = 3'd0;
        for (int i = 0; i < 8; i++) begin
            if (req.wstrb == (8'h01 << i)) begin
                strb_size = bridge_pkg::size_1b;
                strb_offset = 3'(i);
            end
        end
        for (int i = 0; i < 4; i++) begin
            if (req.wstrb == (8'h03 << (2 * i))) begin  // aligned pair
                strb_size = bridge_pkg::size_2b;
                strb_offset = 3'(2 * i);
            end
        end
        for (int i = 0; i < 2; i++) begin
            if (req.wstrb == (8'h0f << (4 * i))) begin
                strb_size = bridge_pkg::size_4b;
                strb_offset = 3'(4 * i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            msg.msg_valid <= 1'b0;
        end else if (take) begin
            msg.msg_valid <= 1'b1;
        end else if (msg.msg_done) begin
            msg.msg_valid <= 1'b0;
        end
    end

    // message fields, held until msg_done
    always_ff @(posedge clk) begin
        if (take) begin
            msg.kind <= req.kind;
            msg.wdata <= req.wdata;
            if (is_store) begin
                msg.msg_type <= bridge_pkg::msg_nc_store_req;
                msg.length <= bridge_pkg::store_length;  // two headers plus data
                msg.address <= {req.addr[bridge_pkg::addr_width-1:3], strb_offset};
                msg.data_size <= strb_size;
            end else begin
                msg.msg_type <= bridge_pkg::msg_nc_load_req;
                msg.length <= bridge_pkg::load_length;
                msg.address <= req.addr;
                msg.data_size <= bridge_pkg::size_8b;
            end
        end
    end

endmodule

`default_nettype wire

// File: flit_serializer.sv
`default_nettype none

module flit_serializer (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [bridge_pkg::chipid_width-1:0] dst_chipid,
    input  logic [bridge_pkg::xy_width-1:0]     dst_x,
    input  logic [bridge_pkg::xy_width-1:0]     dst_y,
    input  logic [bridge_pkg::fbits_width-1:0]  dst_fbits,
    input  logic [bridge_pkg::chipid_width-1:0] src_chipid,
    input  logic [bridge_pkg::xy_width-1:0]     src_x,
    input  logic [bridge_pkg::xy_width-1:0]     src_y,
    input  logic [bridge_pkg::fbits_width-1:0]  src_fbits,
    msg_if.sink                                 msg,
    output logic                                noc_valid,
    input  logic                                noc_ready,
    output logic [bridge_pkg::data_width-1:0]   noc_data
);

    bridge_pkg::flit_state_t state;
    logic [1:0] hdr_cnt;   // header flit index
    logic fire;
    logic last_hdr;
    logic is_store;

    assign noc_valid = (state != bridge_pkg::st_idle);
    assign fire = noc_valid & noc_ready;
    assign is_store = (msg.kind == bridge_pkg::req_store);
    assign last_hdr = (state == bridge_pkg::st_header) &&
                      (hdr_cnt == bridge_pkg::last_hdr_flit);

    // loads end after the headers, stores after the data flit
    assign msg.msg_done = fire & ((last_hdr & ~is_store) | (state == bridge_pkg::st_data));

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= bridge_pkg::st_idle;
            hdr_cnt <= 2'd0;
        end else begin
            case (state)
                bridge_pkg::st_idle: begin
                    if (msg.msg_valid) state <= bridge_pkg::st_header;
                    hdr_cnt <= 2'd0;
                end
                bridge_pkg::st_header: begin
                    if (fire) begin
                        if (last_hdr) begin
                            hdr_cnt <= 2'd0;
                            state <= is_store ? bridge_pkg::st_data : bridge_pkg::st_idle;
                        end else begin
                            hdr_cnt <= hdr_cnt + 2'd1;
                        end
                    end
                end
                bridge_pkg::st_data: begin
                    if (fire) state <= bridge_pkg::st_idle;
                end
                default: state <= bridge_pkg::st_idle;
            endcase
        end
    end

    // flit mux, stable while stalled since msg and state hold
    always_comb begin
        noc_data = '0;
        case (state)
            bridge_pkg::st_header: begin
                case (hdr_cnt)
                    2'd0: begin
                        noc_data[bridge_pkg::hdr0_dst_chipid_lsb +: bridge_pkg::chipid_width] =
                            dst_chipid;
                        noc_data[bridge_pkg::hdr0_dst_x_lsb +: bridge_pkg::xy_width] = dst_x;
                        noc_data[bridge_pkg::hdr0_dst_y_lsb +: bridge_pkg::xy_width] = dst_y;
                        noc_data[bridge_pkg::hdr0_dst_fbits_lsb +: bridge_pkg::fbits_width] =
                            dst_fbits;
                        noc_data[bridge_pkg::hdr0_length_lsb +: bridge_pkg::length_width] =
                            msg.length;
                        noc_data[bridge_pkg::hdr0_type_lsb +: bridge_pkg::type_width] =
                            msg.msg_type;
                        noc_data[bridge_pkg::hdr0_mshrid_lsb +: bridge_pkg::mshrid_width] = '0;
                    end
                    2'd1: begin
                        noc_data[bridge_pkg::hdr1_addr_lsb +: bridge_pkg::msg_addr_width] =
                            {{(bridge_pkg::msg_addr_width - bridge_pkg::addr_width){1'b0}},
                             msg.address};
                        noc_data[bridge_pkg::hdr1_size_lsb +: bridge_pkg::size_width] =
                            msg.data_size;
                    end
                    2'd2: begin
                        noc_data[bridge_pkg::hdr2_src_chipid_lsb +: bridge_pkg::chipid_width] =
                            src_chipid;
                        noc_data[bridge_pkg::hdr2_src_x_lsb +: bridge_pkg::xy_width] = src_x;
                        noc_data[bridge_pkg::hdr2_src_y_lsb +: bridge_pkg::xy_width] = src_y;
                        noc_data[bridge_pkg::hdr2_src_fbits_lsb +: bridge_pkg::fbits_width] =
                            src_fbits;
                    end
                    default: noc_data = '0;
                endcase
            end
            bridge_pkg::st_data: noc_data = msg.wdata;  // single data flit, widths equal
            default: noc_data = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: axilite_noc_bridge.sv
`default_nettype none

module axilite_noc_bridge (
    input  logic                                clk,
    input  logic                                rst,
    // axi-lite write
    input  logic [bridge_pkg::addr_width-1:0]   awaddr,
    input  logic                                awvalid,
    output logic                                awready,
    input  logic [bridge_pkg::data_width-1:0]   wdata,
    input  logic [bridge_pkg::strb_width-1:0]   wstrb,
    input  logic                                wvalid,
    output logic                                wready,
    // axi-lite read address
    input  logic [bridge_pkg::addr_width-1:0]   araddr,
    input  logic                                arvalid,
    output logic                                arready,
    // node identifiers
    input  logic [bridge_pkg::chipid_width-1:0] dst_chipid,
    input  logic [bridge_pkg::xy_width-1:0]     dst_x,
    input  logic [bridge_pkg::xy_width-1:0]     dst_y,
    input  logic [bridge_pkg::fbits_width-1:0]  dst_fbits,
    input  logic [bridge_pkg::chipid_width-1:0] src_chipid,
    input  logic [bridge_pkg::xy_width-1:0]     src_x,
    input  logic [bridge_pkg::xy_width-1:0]     src_y,
    input  logic [bridge_pkg::fbits_width-1:0]  src_fbits,
    // noc request channel
    output logic                                noc_valid,
    output logic [bridge_pkg::data_width-1:0]   noc_data,
    input  logic                                noc_ready
);

    req_if req_bus ();
    msg_if msg_bus ();

    axi_req_decode decode0 (
        .clk(clk), .rst(rst),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .req(req_bus.source)
    );

    msg_former former0 (
        .clk(clk), .rst(rst),
        .req(req_bus.sink),
        .msg(msg_bus.source)
    );

    flit_serializer serializer0 (
        .clk(clk), .rst(rst),
        .dst_chipid(dst_chipid), .dst_x(dst_x), .dst_y(dst_y), .dst_fbits(dst_fbits),
        .src_chipid(src_chipid), .src_x(src_x), .src_y(src_y), .src_fbits(src_fbits),
        .msg(msg_bus.sink),
        .noc_valid(noc_valid), .noc_ready(noc_ready), .noc_data(noc_data)
    );

endmodule

`default_nettype wire

// File: tb_axilite_noc_bridge.sv
`default_nettype none

module tb_axilite_noc_bridge;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [13:0] dst_chipid_val = 14'h01a5;
    localparam logic [7:0] dst_x_val = 8'h03;
    localparam logic [7:0] dst_y_val = 8'h07;
    localparam logic [3:0] dst_fbits_val = 4'ha;
    localparam logic [13:0] src_chipid_val = 14'h002c;
    localparam logic [7:0] src_x_val = 8'h11;
    localparam logic [7:0] src_y_val = 8'h22;
    localparam logic [3:0] src_fbits_val = 4'h5;
    localparam int max_cycles = 200 * 40 + 100;
    localparam int random_reqs = 150;

    logic clk, rst;
    logic [39:0] awaddr, araddr;
    logic awvalid, awready, wvalid, wready, arvalid, arready;
    logic [63:0] wdata, noc_data;
    logic [7:0] wstrb;
    logic [13:0] dst_chipid, src_chipid;
    logic [7:0] dst_x, dst_y, src_x, src_y;
    logic [3:0] dst_fbits, src_fbits;
    logic noc_valid, noc_ready;

    logic [31:0] stim_lfsr = 32'hb55e_61eb;
    logic [31:0] ready_lfsr = 32'hb55e_61eb;
    logic hold_off = 1'b1;          // forces noc_ready low
    logic [63:0] exp_flits[$];
    logic was_stalled = 1'b0;
    logic [63:0] held_flit;
    logic [39:0] rand_addr;
    logic [63:0] rand_data;
    logic [7:0] rand_strb;
    int cycles = 0;
    int fill_count;

    axilite_noc_bridge dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1);
    endtask

    // galois lfsr with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            stim_lfsr = lfsr_next(stim_lfsr);
            v[i] = stim_lfsr[0];
        end
        return v;
    endfunction

    function automatic logic [7:0] pick_strobe();
        logic [2:0] sel;
        logic [7:0] s;
        sel = 3'(take_bits(3));
        case (sel)
            3'd0, 3'd1: s = 8'h01 << take_bits(3);
            3'd2: s = 8'h03 << (2 * take_bits(2));
            3'd3: s = 8'h0f << (4 * take_bits(1));
            3'd4: s = 8'hff;
            default: s = 8'(take_bits(8));  // mostly illegal patterns
        endcase
        return s;
    endfunction

    // expected packet as {data, hdr2, hdr1, hdr0}
    function automatic logic [255:0] ref_packet(input logic is_store, input logic [39:0] a,
                                                input logic [63:0] d, input logic [7:0] s);
        int low;
        int ones;
        logic [2:0] size;
        logic [2:0] offset;
        logic [39:0] msg_addr;
        logic [7:0] len;
        logic [7:0] mtype;
        logic [63:0] f0, f1, f2;
        low = 0;
        ones = 0;
        for (int i = 7; i >= 0; i--) if (s[i]) low = i;
        for (int i = 0; i < 8; i++) ones += s[i];
        size = bridge_pkg::size_8b;
        offset = 3'd0;
        // a legal strobe is one aligned run of 1, 2 or 4 bytes
        if ((ones == 1 || ones == 2 || ones == 4) && (low % ones == 0) &&
            (s == (((8'h01 << ones) - 8'h01) << low))) begin
            size = (ones == 1) ? bridge_pkg::size_1b :
                   (ones == 2) ? bridge_pkg::size_2b : bridge_pkg::size_4b;
            offset = 3'(low);
        end
        if (is_store) begin
            msg_addr = {a[39:3], offset};
            len = 8'd3;
            mtype = bridge_pkg::msg_nc_store_req;
        end else begin
            msg_addr = a;
            len = 8'd2;
            mtype = bridge_pkg::msg_nc_load_req;
            size = bridge_pkg::size_8b;
        end
        f0 = {dst_chipid_val, dst_x_val, dst_y_val, dst_fbits_val, len, mtype, 8'h00, 6'h00};
        f1 = {8'h00, msg_addr, 13'h0000, size};
        f2 = {src_chipid_val, src_x_val, src_y_val, src_fbits_val, 30'h0};
        return {d, f2, f1, f0};
    endfunction

    task automatic record_request(input logic is_store, input logic [39:0] a,
                                  input logic [63:0] d, input logic [7:0] s);
        logic [255:0] pkt;
        pkt = ref_packet(is_store, a, d, s);
        for (int i = 0; i < (is_store ? 4 : 3); i++) exp_flits.push_back(pkt[64*i +: 64]);
    endtask

    // callers enter 5 ns after a rising edge
    task automatic send_store(input logic [39:0] a, input logic [63:0] d, input logic [7:0] s);
        awaddr = a;
        wdata = d;
        wstrb = s;
        awvalid = 1'b1;
        wvalid = 1'b1;
        @(negedge clk);
        while (!awready) @(negedge clk);
        record_request(1'b1, a, d, s);
        @(posedge clk);
        #5;
        awvalid = 1'b0;
        wvalid = 1'b0;
    endtask

    task automatic send_load(input logic [39:0] a);
        araddr = a;
        arvalid = 1'b1;
        @(negedge clk);
        while (!arready) @(negedge clk);
        record_request(1'b0, a, '0, '0);
        @(posedge clk);
        #5;
        arvalid = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_flits.size() != 0) @(negedge clk);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) stop_on_error("timeout, the run did not finish in time");
    end

    // random stalls on the output side
    initial begin
        noc_ready = 1'b0;
        forever begin
            @(posedge clk);
            #5;
            ready_lfsr = lfsr_next(ready_lfsr);
            noc_ready = ready_lfsr[0];
            ready_lfsr = lfsr_next(ready_lfsr);
            noc_ready = ~hold_off & (noc_ready | ready_lfsr[0]);
        end
    end

    // flit checker samples mid cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (was_stalled) begin
                assert (noc_valid && noc_data == held_flit) else
                    stop_on_error($sformatf("error: noc_data held %h got %h (noc_valid %h)",
                                            held_flit, noc_data, noc_valid));
            end
            if (noc_valid) begin
                assert (exp_flits.size() > 0) else
                    stop_on_error("a flit was sent with no request outstanding");
                assert (noc_data == exp_flits[0]) else
                    stop_on_error($sformatf("error: noc_data expected %h got %h",
                                            exp_flits[0], noc_data));
                if (noc_ready) void'(exp_flits.pop_front());
            end
            was_stalled = noc_valid & ~noc_ready;
            held_flit = noc_data;
        end
    end

    initial begin
        rst = 1'b1;
        {awaddr, araddr, wdata, wstrb} = '0;
        {awvalid, wvalid, arvalid} = '0;
        {dst_chipid, dst_x, dst_y, dst_fbits} =
            {dst_chipid_val, dst_x_val, dst_y_val, dst_fbits_val};
        {src_chipid, src_x, src_y, src_fbits} =
            {src_chipid_val, src_x_val, src_y_val, src_fbits_val};
        @(posedge clk);
        @(negedge clk);
        assert (!awready && !wready && !arready && !noc_valid) else
            stop_on_error($sformatf(
                "error: awready wready arready noc_valid expected 0 0 0 0 got %h %h %h %h",
                awready, wready, arready, noc_valid));
        @(posedge clk);
        #5 rst = 1'b0;
        @(negedge clk);
        assert (awready && wready && arready && !noc_valid) else
            stop_on_error($sformatf(
                "error: awready wready arready noc_valid expected 1 1 1 0 got %h %h %h %h",
                awready, wready, arready, noc_valid));
        hold_off = 1'b0;
        @(posedge clk);
        #5;

        for (int i = 0; i < random_reqs; i++) begin
            if (take_bits(1)) begin
                rand_addr = 40'(take_bits(40));
                rand_data = take_bits(64);
                rand_strb = pick_strobe();
                send_store(rand_addr, rand_data, rand_strb);
            end else begin
                send_load(40'(take_bits(40)));
            end
            if (take_bits(2) == 0) begin  // occasional idle cycle
                @(posedge clk);
                #5;
            end
        end

        // each legal strobe once, run lengths 1 2 4 8 at every aligned offset
        for (int n = 1; n <= 8; n = n * 2) begin
            for (int b = 0; b < 8; b = b + n) begin
                rand_addr = 40'(take_bits(40));
                rand_data = take_bits(64);
                rand_strb = 8'(((16'h0001 << n) - 16'h0001) << b);
                send_store(rand_addr, rand_data, rand_strb);
            end
        end

        // store and read together where the store goes first
        awaddr = 40'h12_3456_7890;
        wdata = 64'hfeed_beef_0bad_cafe;
        wstrb = 8'h30;
        araddr = 40'h0a_bcde_f018;
        {awvalid, wvalid, arvalid} = 3'b111;
        @(negedge clk);
        while (!awready) @(negedge clk);
        assert (!arready) else stop_on_error("arready was high while a store was accepted");
        record_request(1'b1, awaddr, wdata, wstrb);
        @(posedge clk);
        #5 {awvalid, wvalid} = 2'b00;
        @(negedge clk);
        while (!arready) @(negedge clk);
        record_request(1'b0, araddr, '0, '0);
        @(posedge clk);
        #5 arvalid = 1'b0;

        // output held off until the queues are full
        wait_drain();
        hold_off = 1'b1;
        fill_count = 0;
        @(posedge clk);
        #5;
        awaddr = 40'(take_bits(40));
        wdata = take_bits(64);
        wstrb = pick_strobe();
        {awvalid, wvalid} = 2'b11;
        @(negedge clk);
        while (awready) begin
            record_request(1'b1, awaddr, wdata, wstrb);
            fill_count++;
            @(posedge clk);
            #5;
            awaddr = 40'(take_bits(40));
            wdata = take_bits(64);
            wstrb = pick_strobe();
            @(negedge clk);
        end
        assert (fill_count >= bridge_pkg::fifo_depth && fill_count <= bridge_pkg::fifo_depth + 1)
            else stop_on_error($sformatf("queue filled after %0d stores", fill_count));
        repeat (3) begin
            assert (!awready && !wready && !arready) else
                stop_on_error($sformatf(
                    "error: awready wready arready expected 0 0 0 got %h %h %h",
                    awready, wready, arready));
            @(negedge clk);
        end
        hold_off = 1'b0;
        @(posedge clk);
        #5 {awvalid, wvalid} = 2'b00;
        wait_drain();
        repeat (10) @(negedge clk);  // any stray flit shows up here
        assert (exp_flits.size() == 0) else stop_on_error("flits still expected at the end");
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
bridge_pkg.sv
bridge_if.sv
req_fifo.sv
axi_req_decode.sv
msg_former.sv
flit_serializer.sv
axilite_noc_bridge.sv
tb_axilite_noc_bridge.sv
